// ==== cbm2_loader_top.f ====
verilog/cbm2_loader_pkg.sv
verilog/loader_apb_regs.sv
verilog/loader_sequencer.sv
verilog/mem_write_port.sv
verilog/cbm2_loader_top.sv
test/cbm2_loader_checker.sv
test/tb_cbm2_loader.sv

// ==== Makefile ====
VERILATOR = verilator
TOP       = tb_cbm2_loader
FILELIST  = cbm2_loader_top.f
FLAGS     = --timing --assert
OBJ_DIR   = obj_dir

.PHONY: sim lint clean

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_cbm2_loader.sv ====
// Banks are 64 bytes and ERASE_GAP is 1, and mem_window pulses every 2 to 9 cycles
module tb_cbm2_loader;
	import cbm2_loader_pkg::*;

	localparam int BANK_W  = 6;
	localparam int BANK_SZ = 1 << BANK_W;
	// Erase 128 and 960 writes, downloads of 20 and 8 bytes plus 4 pointers each
	localparam int TIMEOUT = (128 + 960 + 24 + 12) * 16 + 2000;

	logic        clk_sys    = 1'b0;
	logic        RESET      = 1'b1;
	logic [7:0]  paddr      = 8'd0;
	logic        psel       = 1'b0;
	logic        penable    = 1'b0;
	logic        pwrite     = 1'b0;
	logic [31:0] pwdata     = 32'd0;
	logic        mem_window = 1'b0;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        mem_we;
	addr_t       mem_addr;
	byte_t       mem_data;

	int          seed         = 32'h3269;
	int          cycles       = 0;
	int          gap_cnt      = 0;
	int          stall_cycles = 0;
	logic        hold_window  = 1'b0;
	logic [31:0] rd_data;
	addr_t       log_addr[$];
	byte_t       log_data[$];
	byte_t       payload[$];

	cbm2_loader_top #(
		.BANK_W    (BANK_W),
		.ERASE_GAP (1)
	) u_dut (.*);

	always #2 clk_sys = ~clk_sys;

	task automatic end_with_failure();
		$display(">>> FAIL");
		$fatal(1, "stopping at the first failed check");
	endtask

	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("[FAIL] %s got %0h expected %0h", name, got, exp);
			end_with_failure();
		end
	endtask

	// All ones when bit BANK_W-2, bit 3 and bit 2 xor to 1
	function automatic logic [31:0] fill_byte(input addr_t a);
		return (a[BANK_W-2] ^ a[3] ^ a[2]) ? 32'hFF : 32'h00;
	endfunction

	// ==============================
	// Window, memory model, watchdog
	// ==============================

	// Free-running from time 0, held low only for the back-pressure test
	always @(posedge clk_sys) begin
		if (hold_window) begin
			mem_window <= 1'b0;
		end else if (gap_cnt == 0) begin
			mem_window <= 1'b1;
			gap_cnt    <= 1 + int'($unsigned($random(seed)) % 8);
		end else begin
			mem_window <= 1'b0;
			gap_cnt    <= gap_cnt - 1;
		end
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (mem_we) begin
			log_addr.push_back(mem_addr);
			log_data.push_back(mem_data);
		end
		// Wait states on REG_DATA while the window is held off
		if (hold_window && psel && penable && !pready && paddr == REG_DATA)
			stall_cycles <= stall_cycles + 1;
		if (cycles > TIMEOUT) begin
			$display("Run did not finish within %0d cycles", TIMEOUT);
			end_with_failure();
		end
	end

	// Setup, access, then wait states until pready
	task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata);
		@(posedge clk_sys);
		paddr   <= addr;
		pwrite  <= wr;
		pwdata  <= wdata;
		psel    <= 1'b1;
		penable <= 1'b0;
		@(posedge clk_sys);
		penable <= 1'b1;
		@(posedge clk_sys);
		while (!pready)
			@(posedge clk_sys);
		rd_data = prdata;
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic poll_until_idle();
		apb_access(REG_STATUS, 1'b0, 32'd0);
		while (rd_data[2:0] != 3'd0)
			apb_access(REG_STATUS, 1'b0, 32'd0);
	endtask

	// All writes of one command, then a quiet spell with no extra write
	task automatic collect_writes(input int n);
		while (log_addr.size() < n)
			@(posedge clk_sys);
		repeat (24) @(posedge clk_sys);
		expect_eq("write count", 32'(log_addr.size()), 32'(n));
	endtask

	task automatic erase_banks(input logic [31:0] config_val, input int first_bank,
		input int last_bank);
		bit seen[addr_t];
		int lo;
		int hi;
		lo = first_bank * BANK_SZ;
		hi = (last_bank + 1) * BANK_SZ;
		log_addr.delete();
		log_data.delete();
		apb_access(REG_CONFIG, 1'b1, config_val);
		apb_access(REG_CONTROL, 1'b1, 32'h1);
		poll_until_idle();
		collect_writes(hi - lo);
		foreach (log_addr[i]) begin
			assert (int'(log_addr[i]) >= lo && int'(log_addr[i]) < hi
				&& !seen.exists(log_addr[i])) else begin
				$display("Erase wrote address %0h out of range or twice", log_addr[i]);
				end_with_failure();
			end
			seen[log_addr[i]] = 1'b1;
			expect_eq("mem_data", 32'(log_data[i]), fill_byte(log_addr[i]));
		end
	endtask

	task automatic download_prg(input int n, input bit stall);
		logic [15:0] start;
		logic [15:0] stop;
		logic [31:0] ptrs;
		int          stall_base;
		start = 16'h4000 | 16'($random(seed) & 32'h3FFF);
		stop  = start + 16'(n);
		ptrs  = {stop, start};
		payload.delete();
		log_addr.delete();
		log_data.delete();
		repeat (n)
			payload.push_back(byte_t'($random(seed)));
		stall_base = stall_cycles;
		// System 500 is 128K P, so the payload lands in bank 0
		apb_access(REG_CONFIG, 1'b1, 32'h6);
		apb_access(REG_CONTROL, 1'b1, 32'h2);
		apb_access(REG_DATA, 1'b1, 32'(start[7:0]));
		apb_access(REG_DATA, 1'b1, 32'(start[15:8]));
		fork
			begin
				if (stall) begin
					hold_window <= 1'b1;
					repeat (80) @(posedge clk_sys);
					hold_window <= 1'b0;
				end
			end
			begin
				foreach (payload[i])
					apb_access(REG_DATA, 1'b1, 32'(payload[i]));
			end
		join
		apb_access(REG_CONTROL, 1'b1, 32'h4);
		poll_until_idle();
		collect_writes(n + 4);
		foreach (payload[i]) begin
			expect_eq("mem_addr", 32'(log_addr[i]), 32'(start) + i);
			expect_eq("mem_data", 32'(log_data[i]), 32'(payload[i]));
		end
		// TXTTAB then TXTEND, low byte first
		for (int k = 0; k < 4; k++) begin
			expect_eq("mem_addr", 32'(log_addr[n + k]), PTR_BANK * BANK_SZ + 32'(TXTTAB_OFS) + k);
			expect_eq("mem_data", 32'(log_data[n + k]), 32'(ptrs[8 * k +: 8]));
		end
		assert (!stall || stall_cycles - stall_base >= 32) else begin
			$display("REG_DATA writes were not held off during the long window gap");
			end_with_failure();
		end
	endtask

	initial begin
		repeat (16) @(posedge clk_sys);
		RESET <= 1'b0;
		apb_access(REG_STATUS, 1'b0, 32'd0);
		expect_eq("prdata", rd_data, 32'd0);
		expect_eq("mem_we", 32'(mem_we), 32'd0);
		apb_access(REG_CONFIG, 1'b1, 32'h2A);
		apb_access(REG_CONFIG, 1'b0, 32'd0);
		expect_eq("prdata", rd_data, 32'h2A);
		// 710 is 128K B, banks 1 and 2
		erase_banks(32'h02, 1, 2);
		// Custom P with 1M, banks 0 to 14
		erase_banks(32'h17, 0, 14);
		download_prg(20, 1'b0);
		// Long window gap during the payload
		download_prg(8, 1'b1);
		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== test/cbm2_loader_checker.sv ====
// Bound into cbm2_loader_top, and a host access may wait at most STALL_MAX cycles for pready
module cbm2_loader_checker #(
	parameter int STALL_MAX = 255
) (
	input logic clk_sys,
	input logic RESET,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic mem_we,
	input logic mem_window
);
	int stall_q;

	// Wait states of the current access
	always_ff @(posedge clk_sys) begin
		if (RESET)
			stall_q <= 0;
		else if (psel && penable && !pready)
			stall_q <= stall_q + 1;
		else
			stall_q <= 0;
	end

	// ==============================
	// Memory write port
	// ==============================

	a_we_in_window: assert property (
		@(posedge clk_sys) disable iff (RESET) mem_we |-> mem_window
	) else $error("mem_we high outside mem_window");

	// One write per window
	a_we_single: assert property (
		@(posedge clk_sys) disable iff (RESET) mem_we |=> !mem_we
	) else $error("mem_we high in two consecutive cycles");

	a_we_reset: assert property (
		@(posedge clk_sys) RESET |-> !mem_we
	) else $error("mem_we high during reset");

	// ==============================
	// APB slave
	// ==============================

	a_no_slverr: assert property (
		@(posedge clk_sys) !pslverr
	) else $error("pslverr raised");

	a_pready_rises: assert property (
		@(posedge clk_sys) disable iff (RESET) stall_q < STALL_MAX
	) else $error("pready held low for %0d cycles", STALL_MAX);

endmodule

bind cbm2_loader_top cbm2_loader_checker u_checker (.*);

// ==== verilog/cbm2_loader_top.sv ====
// BANK_W and ERASE_GAP set here are passed to the sequencer, and mem_window comes from the CPU side
module cbm2_loader_top #(
	parameter int BANK_W    = 16,
	parameter int ERASE_GAP = 5
) (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic [7:0]             paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [31:0]            pwdata,
	input  logic                   mem_window,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	output logic                   mem_we,
	output cbm2_loader_pkg::addr_t mem_addr,
	output cbm2_loader_pkg::byte_t mem_data
);
	import cbm2_loader_pkg::*;

	loader_cfg_t cfg;
	logic        erase_start;
	logic        dl_open;
	logic        dl_close;
	logic        byte_valid;
	byte_t       byte_data;
	logic        byte_ready;
	logic        erasing;
	logic        downloading;
	logic        injecting;
	logic        req_valid;
	mem_wr_t     req;
	logic        req_ready;

	// ==============================
	// Host register side
	// ==============================

	loader_apb_regs u_regs (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.paddr       (paddr),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pwdata      (pwdata),
		.byte_ready  (byte_ready),
		.erasing     (erasing),
		.downloading (downloading),
		.injecting   (injecting),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.cfg         (cfg),
		.erase_start (erase_start),
		.dl_open     (dl_open),
		.dl_close    (dl_close),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data)
	);

	loader_sequencer #(
		.BANK_W    (BANK_W),
		.ERASE_GAP (ERASE_GAP)
	) u_seq (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cfg         (cfg),
		.erase_start (erase_start),
		.dl_open     (dl_open),
		.dl_close    (dl_close),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.req_ready   (req_ready),
		.byte_ready  (byte_ready),
		.erasing     (erasing),
		.downloading (downloading),
		.injecting   (injecting),
		.req_valid   (req_valid),
		.req         (req)
	);

	// Memory side
	mem_write_port u_port (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.req_valid  (req_valid),
		.req        (req),
		.mem_window (mem_window),
		.req_ready  (req_ready),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data)
	);

endmodule

// ==== verilog/mem_write_port.sv ====
// One write per mem_window, issued only while the window is high
module mem_write_port (
	input  logic                     clk_sys,
	input  logic                     RESET,
	input  logic                     req_valid,
	input  cbm2_loader_pkg::mem_wr_t req,
	input  logic                     mem_window,
	output logic                     req_ready,
	output logic                     mem_we,
	output cbm2_loader_pkg::addr_t   mem_addr,
	output cbm2_loader_pkg::byte_t   mem_data
);
	import cbm2_loader_pkg::*;

	mem_wr_t entry_q;
	logic    full_q;
	logic    fired_q;

	assign req_ready = !full_q;

	// fired_q marks a window that has already been used
	assign mem_we   = full_q && mem_window && !fired_q;
	assign mem_addr = entry_q.addr;
	assign mem_data = entry_q.data;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			full_q  <= 1'b0;
			fired_q <= 1'b0;
		end else begin
			if (!mem_window)
				fired_q <= 1'b0;
			else if (mem_we)
				fired_q <= 1'b1;

			if (mem_we)
				full_q <= 1'b0;
			else if (req_valid && req_ready)
				full_q <= 1'b1;
		end
	end

	// Entry payload
	always_ff @(posedge clk_sys) begin
		if (req_valid && req_ready)
			entry_q <= req;
	end

endmodule

// ==== verilog/loader_sequencer.sv ====
// Addresses are bank times 2^BANK_W plus offset, and ERASE_GAP must be at least 1
module loader_sequencer #(
	parameter int BANK_W    = 16,
	parameter int ERASE_GAP = 5
) (
	input  logic                        clk_sys,
	input  logic                        RESET,
	input  cbm2_loader_pkg::loader_cfg_t cfg,
	input  logic                        erase_start,
	input  logic                        dl_open,
	input  logic                        dl_close,
	input  logic                        byte_valid,
	input  cbm2_loader_pkg::byte_t      byte_data,
	input  logic                        req_ready,
	output logic                        byte_ready,
	output logic                        erasing,
	output logic                        downloading,
	output logic                        injecting,
	output logic                        req_valid,
	output cbm2_loader_pkg::mem_wr_t    req
);
	import cbm2_loader_pkg::*;

	function automatic addr_t bank_base(input logic [8:0] bank);
		return addr_t'(bank) << BANK_W;
	endfunction

	logic [ERASE_GAP-1:0] gap_q;
	logic [1:0]           hdr_cnt;
	logic [2:0]           inj_idx;
	logic [15:0]          start_q;
	logic [15:0]          end_q;
	addr_t                addr_q;
	logic [8:0]           first_bank;
	logic [8:0]           end_bank;
	addr_t                erase_stop;
	logic                 erase_fill;
	logic                 busy;
	logic                 byte_take;
	logic                 erase_due;
	logic                 inj_issue;
	byte_t                inj_data;
	logic [7:0]           inj_ofs;

	assign busy       = erasing | downloading | injecting;
	assign byte_ready = !req_valid && !erasing && !injecting;
	assign byte_take  = byte_valid && byte_ready;
	assign erase_due  = erasing && !req_valid && (&gap_q);
	assign inj_issue  = injecting && !req_valid && !inj_idx[2];

	// Bank 1 for B machines, bank 0 for P
	assign first_bank = {8'd0, cfg.model_b};

	// Last bank covered by the erase
	always_comb begin
		case (cfg.ram_size)
			2'd1:    end_bank = cfg.model_b ? 9'd2 : 9'd1;
			2'd2:    end_bank = 9'd14;
			default: end_bank = cfg.model_b ? 9'd4 : 9'd3;
		endcase
	end

	assign erase_stop = bank_base(end_bank + 9'd1);

	// Same striped pattern the core leaves in fresh RAM
	assign erase_fill = addr_q[BANK_W-2] ^ addr_q[3] ^ addr_q[2];

	// TXTTAB then TXTEND, low byte first
	always_comb begin
		case (inj_idx[1:0])
			2'd0: inj_data = start_q[7:0];
			2'd1: inj_data = start_q[15:8];
			2'd2: inj_data = end_q[7:0];
			default: inj_data = end_q[15:8];
		endcase
		inj_ofs = (inj_idx[1] ? TXTEND_OFS : TXTTAB_OFS) + {7'd0, inj_idx[0]};
	end

	// ==============================
	// Activity control
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			erasing     <= 1'b0;
			downloading <= 1'b0;
			injecting   <= 1'b0;
			req_valid   <= 1'b0;
			gap_q       <= '0;
			hdr_cnt     <= 2'd0;
			inj_idx     <= 3'd0;
		end else begin
			if (req_valid && req_ready)
				req_valid <= 1'b0;

			// Erase wins over a download opened in the same cycle
			if (!busy) begin
				if (erase_start) begin
					erasing <= 1'b1;
					gap_q   <= '0;
				end else if (dl_open) begin
					downloading <= 1'b1;
					hdr_cnt     <= 2'd0;
				end
			end

			// Pace counter only runs while no request is outstanding
			if (erasing && !req_valid) begin
				gap_q <= gap_q + 1'b1;
				if (&gap_q) begin
					if (addr_q == erase_stop)
						erasing <= 1'b0;
					else
						req_valid <= 1'b1;
				end
			end

			if (downloading) begin
				if (byte_take) begin
					if (hdr_cnt[1])
						req_valid <= 1'b1;
					else
						hdr_cnt <= hdr_cnt + 2'd1;
				end
				if (dl_close) begin
					downloading <= 1'b0;
					injecting   <= 1'b1;
					inj_idx     <= 3'd0;
				end
			end

			if (injecting && !req_valid) begin
				if (inj_idx[2]) begin
					injecting <= 1'b0;
				end else begin
					req_valid <= 1'b1;
					inj_idx   <= inj_idx + 3'd1;
				end
			end
		end
	end

	// ==============================
	// Address counter and request
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (!busy && erase_start)
			addr_q <= bank_base(first_bank);

		if (erase_due && addr_q != erase_stop) begin
			req.addr <= addr_q;
			req.data <= {8{erase_fill}};
			addr_q   <= addr_q + 1'b1;
		end

		// Header bytes then payload, bytes outside a download are dropped
		if (downloading && byte_take) begin
			case (hdr_cnt)
				2'd0: start_q[7:0] <= byte_data;
				2'd1: begin
					start_q[15:8] <= byte_data;
					end_q         <= {byte_data, start_q[7:0]};
					addr_q        <= bank_base(first_bank) + addr_t'({byte_data, start_q[7:0]});
				end
				default: begin
					req.addr <= addr_q;
					req.data <= byte_data;
					addr_q   <= addr_q + 1'b1;
					end_q    <= end_q + 16'd1;
				end
			endcase
		end

		if (inj_issue) begin
			req.addr <= bank_base(9'(PTR_BANK)) + addr_t'(inj_ofs);
			req.data <= inj_data;
		end
	end

endmodule

// ==== verilog/loader_apb_regs.sv ====
// Each REG_DATA write holds pready low until the sequencer has taken its byte, so a byte is never dropped
module loader_apb_regs (
	input  logic                        clk_sys,
	input  logic                        RESET,
	input  logic [7:0]                  paddr,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [31:0]                 pwdata,
	input  logic                        byte_ready,
	input  logic                        erasing,
	input  logic                        downloading,
	input  logic                        injecting,
	output logic [31:0]                 prdata,
	output logic                        pready,
	output logic                        pslverr,
	output cbm2_loader_pkg::loader_cfg_t cfg,
	output logic                        erase_start,
	output logic                        dl_open,
	output logic                        dl_close,
	output logic                        byte_valid,
	output cbm2_loader_pkg::byte_t      byte_data
);
	import cbm2_loader_pkg::*;

	logic [5:0] config_q;
	logic       data_done;
	logic       access;
	logic       wr_access;
	logic       cfg_wr;
	logic       ctrl_wr;
	logic       data_wr;

	// ==============================
	// Access decode
	// ==============================

	assign access    = psel & penable;
	assign wr_access = access & pwrite;
	assign cfg_wr    = wr_access && (paddr == REG_CONFIG);
	assign ctrl_wr   = wr_access && (paddr == REG_CONTROL);
	assign data_wr   = wr_access && (paddr == REG_DATA);

	// Data writes wait for the handoff, everything else completes at once
	assign pready  = !data_wr || data_done;
	assign pslverr = 1'b0;

	// Bits 2:0 system, bits 5:3 custom fields
	assign cfg = decode_cfg(sys_sel_t'(config_q[2:0]), config_q[5:3]);

	always_comb begin
		case (paddr)
			REG_CONFIG: prdata = {26'd0, config_q};
			REG_STATUS: prdata = {29'd0, injecting, downloading, erasing};
			default:    prdata = 32'd0;
		endcase
	end

	// ==============================
	// Control and byte handoff
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			config_q    <= 6'd0;
			erase_start <= 1'b0;
			dl_open     <= 1'b0;
			dl_close    <= 1'b0;
			byte_valid  <= 1'b0;
			data_done   <= 1'b0;
		end else begin
			// One-cycle pulses after the access phase
			erase_start <= ctrl_wr & pwdata[0];
			dl_open     <= ctrl_wr & pwdata[1];
			dl_close    <= ctrl_wr & pwdata[2];

			if (cfg_wr)
				config_q <= pwdata[5:0];

			if (byte_valid && byte_ready) begin
				byte_valid <= 1'b0;
				data_done  <= 1'b1;
			end else if (data_wr && !byte_valid && !data_done) begin
				byte_valid <= 1'b1;
			end

			// Access completes this cycle
			if (data_wr && data_done)
				data_done <= 1'b0;
		end
	end

	// Byte payload
	always_ff @(posedge clk_sys) begin
		if (data_wr && !byte_valid && !data_done)
			byte_data <= pwdata[7:0];
	end

endmodule

// ==== verilog/cbm2_loader_pkg.sv ====
// Loader addresses are bank and offset concatenated, so code must honour the BANK_W in use
package cbm2_loader_pkg;

	// ==============================
	// Basic types
	// ==============================

	typedef logic [24:0] addr_t;
	typedef logic [7:0]  byte_t;

	// 0..7 select 730 720 710 630 620 610 500 and custom
	typedef logic [2:0] sys_sel_t;

	// model_b 0 is P and 1 is B
	// ram_size 0 is 256K, 1 is 128K, 2 is 1M
	typedef struct packed {
		logic       model_b;
		logic [1:0] ram_size;
	} loader_cfg_t;

	typedef struct packed {
		addr_t addr;
		byte_t data;
	} mem_wr_t;

	// ==============================
	// APB register map
	// ==============================

	localparam logic [7:0] REG_CONFIG  = 8'h00;
	localparam logic [7:0] REG_CONTROL = 8'h04;
	localparam logic [7:0] REG_DATA    = 8'h08;
	localparam logic [7:0] REG_STATUS  = 8'h0C;

	// BASIC pointers, two bytes each, low byte first
	localparam int unsigned PTR_BANK   = 15;
	localparam logic [7:0]  TXTTAB_OFS = 8'h2D;
	localparam logic [7:0]  TXTEND_OFS = 8'h2F;

	// System selection to model and RAM size
	// Custom takes model from cust[2] and RAM size from cust[1:0]
	function automatic loader_cfg_t decode_cfg(input sys_sel_t sel, input logic [2:0] cust);
		loader_cfg_t c;
		case (sel)
			3'd0, 3'd1, 3'd3, 3'd4: begin
				c.model_b  = 1'b1;
				c.ram_size = 2'd0;
			end
			3'd2, 3'd5: begin
				c.model_b  = 1'b1;
				c.ram_size = 2'd1;
			end
			3'd6: begin
				c.model_b  = 1'b0;
				c.ram_size = 2'd1;
			end
			default: begin
				c.model_b  = cust[2];
				c.ram_size = cust[1:0];
			end
		endcase
		return c;
	endfunction

endpackage
